/* Bender.yml */
package:
  name: debugger

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/dbg_bus_pkg.sv
      - verilog/dbg_cmd_pkg.sv
      - verilog/spi_peripheral.sv
      - verilog/debug_commander.sv
      - verilog/debug_values.sv
      - verilog/mem_arbiter.sv
      - verilog/debug_memory.sv
      - verilog/debugger_top.sv
  - target: test
    files:
      - bench/debugger_tb.sv

/* bench/debugger_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module debugger_tb;

    localparam int CLK_PERIOD = 200;
    localparam int HALF_SCK   = 8;
    localparam int FRAME_GAP  = 16;
    localparam int MAX_TESTS  = 24;
    localparam int MAX_BYTES  = 8;
    // Longest frame with chip select setup and gap, in clock cycles
    localparam int FRAME_CYCLES = MAX_BYTES * 8 * 2 * HALF_SCK + 2 * HALF_SCK + FRAME_GAP;

    logic               i_clk_5mhz;
    logic               i_reset_n;
    logic               i_spi_cs_n;
    logic               i_spi_clk;
    logic               i_spi_copi;
    logic               o_spi_cipo;
    logic               i_cpu_rw;
    dbg_bus_pkg::addr_t i_cpu_address;
    dbg_bus_pkg::byte_t i_cpu_data;
    dbg_bus_pkg::byte_t o_cpu_data;
    dbg_bus_pkg::byte_t i_cpu_reg_a;
    dbg_bus_pkg::byte_t i_cpu_reg_x;
    dbg_bus_pkg::byte_t i_cpu_reg_y;
    dbg_bus_pkg::byte_t i_cpu_reg_s;
    dbg_bus_pkg::byte_t i_cpu_reg_p;
    logic               o_cpu_clk_en;
    logic               o_cpu_reset_n;

    // Frame table, one row per test
    string              t_name  [0:MAX_TESTS-1];
    int                 t_len   [0:MAX_TESTS-1];
    dbg_bus_pkg::byte_t t_tx    [0:MAX_TESTS-1][0:MAX_BYTES-1];
    dbg_bus_pkg::byte_t t_exp   [0:MAX_TESTS-1][0:MAX_BYTES-1];
    logic               t_rst   [0:MAX_TESTS-1];
    int                 t_steps [0:MAX_TESTS-1];

    int                 n_tests      = 0;
    int                 errors       = 0;
    int                 failed_tests = 0;
    int                 step_num     = 0;
    logic               clk_en_prev  = 1'b0;
    logic               table_ready  = 1'b0;
    logic [31:0]        rng          = 32'h5ce8;
    dbg_bus_pkg::byte_t wr_data [0:3];

    debugger_top DUT (
        .i_clk_5mhz    (i_clk_5mhz),
        .i_reset_n     (i_reset_n),
        .i_spi_cs_n    (i_spi_cs_n),
        .i_spi_clk     (i_spi_clk),
        .i_spi_copi    (i_spi_copi),
        .o_spi_cipo    (o_spi_cipo),
        .i_cpu_rw      (i_cpu_rw),
        .i_cpu_address (i_cpu_address),
        .i_cpu_data    (i_cpu_data),
        .o_cpu_data    (o_cpu_data),
        .i_cpu_reg_a   (i_cpu_reg_a),
        .i_cpu_reg_x   (i_cpu_reg_x),
        .i_cpu_reg_y   (i_cpu_reg_y),
        .i_cpu_reg_s   (i_cpu_reg_s),
        .i_cpu_reg_p   (i_cpu_reg_p),
        .o_cpu_clk_en  (o_cpu_clk_en),
        .o_cpu_reset_n (o_cpu_reset_n)
    );

    initial
        i_clk_5mhz = 1'b0;

    always #(CLK_PERIOD / 2) i_clk_5mhz = ~i_clk_5mhz;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Return 10 ns after the n-th rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i_clk_5mhz);
        #10;
    endtask

    task automatic begin_test(input string name, input logic rst, input int steps);
        t_name[n_tests]  = name;
        t_len[n_tests]   = 0;
        t_rst[n_tests]   = rst;
        t_steps[n_tests] = steps;
        n_tests++;
    endtask

    task automatic push_byte(input dbg_bus_pkg::byte_t tx, input dbg_bus_pkg::byte_t exp);
        t_tx[n_tests-1][t_len[n_tests-1]]  = tx;
        t_exp[n_tests-1][t_len[n_tests-1]] = exp;
        t_len[n_tests-1]++;
    endtask

    // Value answer comes in bytes 3 and 4, high byte first
    task automatic queue_value_read(input string name, input logic [15:0] id,
                                    input logic [15:0] value, input logic rst, input int steps);
        begin_test(name, rst, steps);
        push_byte(dbg_cmd_pkg::CMD_VALUE_READ, 8'h00);
        push_byte(id[15:8], 8'h00);
        push_byte(id[7:0], 8'h00);
        push_byte(8'h00, value[15:8]);
        push_byte(8'h00, value[7:0]);
    endtask

    task automatic queue_value_write(input string name, input logic [15:0] id,
                                     input logic [15:0] data, input logic rst, input int steps);
        begin_test(name, rst, steps);
        push_byte(dbg_cmd_pkg::CMD_VALUE_WRITE, 8'h00);
        push_byte(id[15:8], 8'h00);
        push_byte(id[7:0], 8'h00);
        push_byte(data[15:8], 8'h00);
        push_byte(data[7:0], 8'h00);
    endtask

    task automatic build_table;
        int k;
        queue_value_read("step_count_reset", dbg_cmd_pkg::VID_STEP_COUNT, 16'h0000, 1'b1, 0);
        // Four bytes from 0x0FFE wrap onto index 0 and 1
        begin_test("mem_write_wrap", 1'b1, 0);
        push_byte(dbg_cmd_pkg::CMD_MEM_WRITE, 8'h00);
        push_byte(8'h0F, 8'h00);
        push_byte(8'hFE, 8'h00);
        for (k = 0; k < 4; k++)
            push_byte(wr_data[k], 8'h00);
        begin_test("mem_read_wrap", 1'b1, 0);
        push_byte(dbg_cmd_pkg::CMD_MEM_READ, 8'h00);
        push_byte(8'h0F, 8'h00);
        push_byte(8'hFE, 8'h00);
        for (k = 0; k < 4; k++)
            push_byte(8'h00, wr_data[k]);
        begin_test("mem_read_index0", 1'b1, 0);
        push_byte(dbg_cmd_pkg::CMD_MEM_READ, 8'h00);
        push_byte(8'h00, 8'h00);
        push_byte(8'h00, 8'h00);
        push_byte(8'h00, wr_data[2]);
        push_byte(8'h00, wr_data[3]);
        queue_value_read("reg_a", dbg_cmd_pkg::VID_REG_A, {8'h00, i_cpu_reg_a}, 1'b1, 0);
        queue_value_read("reg_x", dbg_cmd_pkg::VID_REG_X, {8'h00, i_cpu_reg_x}, 1'b1, 0);
        queue_value_read("reg_y", dbg_cmd_pkg::VID_REG_Y, {8'h00, i_cpu_reg_y}, 1'b1, 0);
        queue_value_read("reg_s", dbg_cmd_pkg::VID_REG_S, {8'h00, i_cpu_reg_s}, 1'b1, 0);
        queue_value_read("reg_p", dbg_cmd_pkg::VID_REG_P, {8'h00, i_cpu_reg_p}, 1'b1, 0);
        queue_value_read("cpu_address", dbg_cmd_pkg::VID_ADDRESS, 16'h0100, 1'b1, 0);
        queue_value_read("unknown_id", 16'h0033, 16'h0000, 1'b1, 0);
        for (k = 1; k <= 3; k++)
            queue_value_write($sformatf("step_%0d", k), dbg_cmd_pkg::VID_STEP, 16'h0001, 1'b1, k);
        queue_value_read("step_count", dbg_cmd_pkg::VID_STEP_COUNT, 16'd3, 1'b1, 3);
        // Each step wrote its own number at 0x0100 + step
        begin_test("step_writes", 1'b1, 3);
        push_byte(dbg_cmd_pkg::CMD_MEM_READ, 8'h00);
        push_byte(8'h01, 8'h00);
        push_byte(8'h00, 8'h00);
        for (k = 0; k < 3; k++)
            push_byte(8'h00, 8'(k));
        queue_value_write("cpu_reset_on", dbg_cmd_pkg::VID_CPU_RESET, 16'h0001, 1'b0, 3);
        queue_value_read("cpu_reset_read", dbg_cmd_pkg::VID_CPU_RESET, 16'h0001, 1'b0, 3);
        queue_value_write("cpu_reset_off", dbg_cmd_pkg::VID_CPU_RESET, 16'h0000, 1'b1, 3);
        begin_test("unknown_cmd", 1'b1, 3);
        push_byte(8'h55, 8'h00);
        push_byte(8'h12, 8'h00);
        push_byte(8'h34, 8'h00);
        push_byte(8'h56, 8'h00);
        queue_value_read("after_unknown", dbg_cmd_pkg::VID_STEP_COUNT, 16'd3, 1'b1, 3);
    endtask

    // Mode 0 host, SCK at one sixteenth of the clock
    task automatic run_frame(input int idx);
        dbg_bus_pkg::byte_t rx;
        int b;
        int i;
        i_spi_cs_n = 1'b0;
        wait_cycles(HALF_SCK);
        for (b = 0; b < t_len[idx]; b++)
        begin
            rx = 8'h00;
            for (i = 7; i >= 0; i--)
            begin
                i_spi_copi = t_tx[idx][b][i];
                wait_cycles(HALF_SCK);
                i_spi_clk = 1'b1;
                rx = {rx[6:0], o_spi_cipo};
                wait_cycles(HALF_SCK);
                i_spi_clk = 1'b0;
            end
            assert (rx === t_exp[idx][b])
            else
            begin
                $display("FAILED at %0t ns: %s byte %0d read %02h, expected %02h",
                         $time, t_name[idx], b, rx, t_exp[idx][b]);
                errors++;
            end
        end
        wait_cycles(HALF_SCK);
        i_spi_cs_n = 1'b1;
        i_spi_copi = 1'b0;
        wait_cycles(FRAME_GAP);
    endtask

    task automatic check_pins(input string name, input logic rst, input int steps);
        assert (o_cpu_clk_en === 1'b0)
        else
        begin
            $display("FAILED at %0t ns: %s step enable is high when idle", $time, name);
            errors++;
        end
        assert (o_cpu_reset_n === rst)
        else
        begin
            $display("FAILED at %0t ns: %s processor reset_n is %b, expected %b",
                     $time, name, o_cpu_reset_n, rst);
            errors++;
        end
        assert (step_num == steps)
        else
        begin
            $display("FAILED at %0t ns: %s saw %0d step pulses, expected %0d",
                     $time, name, step_num, steps);
            errors++;
        end
        // Processor bus reads back the byte of its last step while the debugger is idle
        if (steps > 0)
        begin
            assert (o_cpu_data === 8'(steps - 1))
            else
            begin
                $display("FAILED at %0t ns: %s processor read %02h, expected %02h",
                         $time, name, o_cpu_data, 8'(steps - 1));
                errors++;
            end
        end
    endtask

    // Processor model writes its step number at 0x0100 + step on each step pulse
    always @(posedge i_clk_5mhz)
    begin
        #10;
        if (o_cpu_clk_en)
        begin
            assert (!clk_en_prev)
            else
            begin
                $display("FAILED at %0t ns: step enable high for two cycles in a row", $time);
                errors++;
            end
            i_cpu_rw      = 1'b0;
            i_cpu_address = 16'h0100 + 16'(step_num);
            i_cpu_data    = 8'(step_num);
            step_num++;
        end
        else
        begin
            i_cpu_rw = 1'b1;
        end
        clk_en_prev = o_cpu_clk_en;
    end

    initial
    begin
        int i;
        int errors_before;
        i_reset_n     = 1'b0;
        i_spi_cs_n    = 1'b1;
        i_spi_clk     = 1'b0;
        i_spi_copi    = 1'b0;
        i_cpu_rw      = 1'b1;
        i_cpu_address = 16'h0100;
        i_cpu_data    = 8'h00;
        rng = next_rand(rng);
        i_cpu_reg_a = rng[7:0];
        rng = next_rand(rng);
        i_cpu_reg_x = rng[7:0];
        rng = next_rand(rng);
        i_cpu_reg_y = rng[7:0];
        rng = next_rand(rng);
        i_cpu_reg_s = rng[7:0];
        rng = next_rand(rng);
        i_cpu_reg_p = rng[7:0];
        for (i = 0; i < 4; i++)
        begin
            rng = next_rand(rng);
            wr_data[i] = rng[7:0];
        end
        build_table();
        table_ready = 1'b1;

        wait_cycles(5);
        i_reset_n = 1'b1;
        wait_cycles(2);
        check_pins("after_reset", 1'b1, 0);

        for (i = 0; i < n_tests; i++)
        begin
            errors_before = errors;
            run_frame(i);
            check_pins(t_name[i], t_rst[i], t_steps[i]);
            if (errors == errors_before)
                $display("test %0d %s: ok", i, t_name[i]);
            else
            begin
                failed_tests++;
                $display("test %0d %s: mismatch", i, t_name[i]);
            end
        end

        $display("%0d tests, %0d failed, %0d check errors", n_tests, failed_tests, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Twice the table time plus one frame for reset
    initial
    begin
        wait (table_ready);
        #((n_tests + 1) * FRAME_CYCLES * CLK_PERIOD * 2);
        $display("Watchdog timeout, the frame table did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/dbg_bus_pkg.sv
verilog/dbg_cmd_pkg.sv
verilog/spi_peripheral.sv
verilog/debug_commander.sv
verilog/debug_values.sv
verilog/mem_arbiter.sv
verilog/debug_memory.sv
verilog/debugger_top.sv
bench/debugger_tb.sv

/* verilog/dbg_bus_pkg.sv */
`default_nettype none

package dbg_bus_pkg;

    // Data byte on the SPI link, memory and processor bus
    typedef logic [7:0] byte_t;

    // Processor and debugger address
    typedef logic [15:0] addr_t;

    // Value port data and identifier
    typedef logic [15:0] value_t;
    typedef logic [15:0] value_id_t;

endpackage

`default_nettype wire

/* verilog/dbg_cmd_pkg.sv */
`default_nettype none

package dbg_cmd_pkg;

    // First byte of every frame
    typedef enum logic [7:0] {
        CMD_MEM_READ    = 8'h10,
        CMD_MEM_WRITE   = 8'h11,
        CMD_VALUE_READ  = 8'h20,
        CMD_VALUE_WRITE = 8'h21
    } cmd_e;

    typedef enum logic [2:0] {
        ST_CMD,
        ST_ARG_HI,
        ST_ARG_LO,
        ST_STREAM,
        ST_DATA_HI,
        ST_DATA_LO,
        ST_IGNORE
    } cmdr_state_e;

    // Unlisted IDs read 0 and ignore writes
    typedef enum logic [15:0] {
        VID_STEP       = 16'h0000,
        VID_STEP_COUNT = 16'h0001,
        VID_CPU_RESET  = 16'h0002,
        VID_ADDRESS    = 16'h0010,
        VID_REG_A      = 16'h0011,
        VID_REG_X      = 16'h0012,
        VID_REG_Y      = 16'h0013,
        VID_REG_S      = 16'h0014,
        VID_REG_P      = 16'h0015
    } value_id_e;

endpackage

`default_nettype wire

/* verilog/dbg_params.svh */
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Memory index width, 4096 bytes
`define DBG_MEM_ADDR_BITS 12

// Flip-flops on each SPI input pin
`define DBG_SYNC_STAGES 2

`endif

/* verilog/debug_commander.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_commander (
    input  wire                        i_clk_5mhz,
    input  wire                        i_reset_n,
    input  wire                        i_rx_dv,
    input  wire dbg_bus_pkg::byte_t    i_rx_byte,
    input  wire                        i_active,
    output wire                        o_tx_dv,
    output dbg_bus_pkg::byte_t         o_tx_byte,
    output logic                       o_mem_en,
    output logic                       o_mem_we,
    output dbg_bus_pkg::addr_t         o_mem_address,
    output dbg_bus_pkg::byte_t         o_mem_wdata,
    input  wire dbg_bus_pkg::byte_t    i_mem_rdata,
    output logic                       o_value_en,
    output logic                       o_value_we,
    output dbg_bus_pkg::value_id_t     o_value_id,
    output dbg_bus_pkg::value_t        o_value_wdata,
    input  wire dbg_bus_pkg::value_t   i_value_rdata
);

    dbg_cmd_pkg::cmdr_state_e state;
    dbg_cmd_pkg::cmd_e        cmd;
    dbg_bus_pkg::byte_t       arg_hi;
    dbg_bus_pkg::byte_t       val_lo;
    dbg_bus_pkg::byte_t       tx_byte_q;
    dbg_bus_pkg::addr_t       addr_cnt;
    dbg_bus_pkg::addr_t       arg_word;
    logic                     tx_dv_q;
    logic                     mem_rd_wait;
    logic                     val_rd;

    assign arg_word = {arg_hi, i_rx_byte};
    assign val_rd   = o_value_en & ~o_value_we;

    // Memory data is valid the cycle after the read enable
    assign o_tx_dv   = tx_dv_q | mem_rd_wait;
    assign o_tx_byte = mem_rd_wait ? i_mem_rdata : tx_byte_q;

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            state         <= dbg_cmd_pkg::ST_CMD;
            cmd           <= dbg_cmd_pkg::CMD_MEM_READ;
            arg_hi        <= '0;
            val_lo        <= '0;
            tx_byte_q     <= '0;
            tx_dv_q       <= 1'b0;
            addr_cnt      <= '0;
            mem_rd_wait   <= 1'b0;
            o_mem_en      <= 1'b0;
            o_mem_we      <= 1'b0;
            o_mem_address <= '0;
            o_mem_wdata   <= '0;
            o_value_en    <= 1'b0;
            o_value_we    <= 1'b0;
            o_value_id    <= '0;
            o_value_wdata <= '0;
        end
        else
        begin
            o_mem_en    <= 1'b0;
            o_value_en  <= 1'b0;
            tx_dv_q     <= 1'b0;
            mem_rd_wait <= o_mem_en & ~o_mem_we;

            // Value data is combinational, high byte answers now
            if (val_rd)
            begin
                tx_dv_q   <= 1'b1;
                tx_byte_q <= i_value_rdata[15:8];
                val_lo    <= i_value_rdata[7:0];
            end

            if (!i_active)
            begin
                state <= dbg_cmd_pkg::ST_CMD;
            end
            else if (i_rx_dv)
            begin
                case (state)
                    dbg_cmd_pkg::ST_CMD:
                    begin
                        cmd <= dbg_cmd_pkg::cmd_e'(i_rx_byte);
                        case (i_rx_byte)
                            dbg_cmd_pkg::CMD_MEM_READ, dbg_cmd_pkg::CMD_MEM_WRITE,
                            dbg_cmd_pkg::CMD_VALUE_READ, dbg_cmd_pkg::CMD_VALUE_WRITE:
                                state <= dbg_cmd_pkg::ST_ARG_HI;
                            default:
                                state <= dbg_cmd_pkg::ST_IGNORE;
                        endcase
                    end
                    dbg_cmd_pkg::ST_ARG_HI:
                    begin
                        arg_hi <= i_rx_byte;
                        state  <= dbg_cmd_pkg::ST_ARG_LO;
                    end
                    dbg_cmd_pkg::ST_ARG_LO:
                    begin
                        o_value_id <= arg_word;
                        addr_cnt   <= arg_word;
                        state      <= dbg_cmd_pkg::ST_DATA_HI;
                        case (cmd)
                            dbg_cmd_pkg::CMD_MEM_READ:
                            begin
                                // First byte is fetched before the stream starts
                                o_mem_en      <= 1'b1;
                                o_mem_we      <= 1'b0;
                                o_mem_address <= arg_word;
                                addr_cnt      <= arg_word + 16'd1;
                                state         <= dbg_cmd_pkg::ST_STREAM;
                            end
                            dbg_cmd_pkg::CMD_MEM_WRITE:
                                state <= dbg_cmd_pkg::ST_STREAM;
                            dbg_cmd_pkg::CMD_VALUE_READ:
                            begin
                                o_value_en <= 1'b1;
                                o_value_we <= 1'b0;
                            end
                            default:
                                state <= dbg_cmd_pkg::ST_DATA_HI;
                        endcase
                    end
                    dbg_cmd_pkg::ST_STREAM:
                    begin
                        o_mem_en      <= 1'b1;
                        o_mem_we      <= (cmd == dbg_cmd_pkg::CMD_MEM_WRITE);
                        o_mem_address <= addr_cnt;
                        o_mem_wdata   <= i_rx_byte;
                        addr_cnt      <= addr_cnt + 16'd1;
                    end
                    dbg_cmd_pkg::ST_DATA_HI:
                    begin
                        if (cmd == dbg_cmd_pkg::CMD_VALUE_READ)
                        begin
                            tx_dv_q   <= 1'b1;
                            tx_byte_q <= val_lo;
                        end
                        o_value_wdata[15:8] <= i_rx_byte;
                        state               <= dbg_cmd_pkg::ST_DATA_LO;
                    end
                    dbg_cmd_pkg::ST_DATA_LO:
                    begin
                        if (cmd == dbg_cmd_pkg::CMD_VALUE_WRITE)
                        begin
                            o_value_en <= 1'b1;
                            o_value_we <= 1'b1;
                        end
                        o_value_wdata[7:0] <= i_rx_byte;
                        state              <= dbg_cmd_pkg::ST_IGNORE;
                    end
                    default:
                        state <= dbg_cmd_pkg::ST_IGNORE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/debug_memory.sv */
`timescale 1ns/1ps
`include "dbg_params.svh"
`default_nettype none

module debug_memory (
    input  wire                          i_clk_5mhz,
    input  wire                          i_en,
    input  wire                          i_we,
    input  wire [`DBG_MEM_ADDR_BITS-1:0] i_index,
    input  wire dbg_bus_pkg::byte_t      i_wdata,
    output dbg_bus_pkg::byte_t           o_rdata
);

    dbg_bus_pkg::byte_t mem [0:(1 << `DBG_MEM_ADDR_BITS)-1];

    // Read-first, output registered
    always_ff @(posedge i_clk_5mhz)
    begin
        if (i_en)
        begin
            if (i_we)
                mem[i_index] <= i_wdata;
            o_rdata <= mem[i_index];
        end
    end

endmodule

`default_nettype wire

/* verilog/debug_values.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_values (
    input  wire                         i_clk_5mhz,
    input  wire                         i_reset_n,
    input  wire                         i_en,
    input  wire                         i_we,
    input  wire dbg_bus_pkg::value_id_t i_id,
    input  wire dbg_bus_pkg::value_t    i_wdata,
    output dbg_bus_pkg::value_t         o_rdata,
    input  wire dbg_bus_pkg::addr_t     i_cpu_address,
    input  wire dbg_bus_pkg::byte_t     i_cpu_reg_a,
    input  wire dbg_bus_pkg::byte_t     i_cpu_reg_x,
    input  wire dbg_bus_pkg::byte_t     i_cpu_reg_y,
    input  wire dbg_bus_pkg::byte_t     i_cpu_reg_s,
    input  wire dbg_bus_pkg::byte_t     i_cpu_reg_p,
    output logic                        o_cpu_clk_en,
    output wire                         o_cpu_reset_n
);

    dbg_bus_pkg::value_t step_count;
    logic                cpu_reset;
    logic                wr;

    assign wr            = i_en & i_we;
    assign o_cpu_reset_n = ~cpu_reset;

    // Step pulse and count change on the same edge
    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_cpu_clk_en <= 1'b0;
            step_count   <= '0;
            cpu_reset    <= 1'b0;
        end
        else
        begin
            o_cpu_clk_en <= wr && (i_id == dbg_cmd_pkg::VID_STEP);
            if (wr && (i_id == dbg_cmd_pkg::VID_STEP))
                step_count <= step_count + 16'd1;
            if (wr && (i_id == dbg_cmd_pkg::VID_CPU_RESET))
                cpu_reset <= i_wdata[0];
        end
    end

    always_comb
    begin
        case (i_id)
            dbg_cmd_pkg::VID_STEP_COUNT: o_rdata = step_count;
            dbg_cmd_pkg::VID_CPU_RESET:  o_rdata = {15'd0, cpu_reset};
            dbg_cmd_pkg::VID_ADDRESS:    o_rdata = i_cpu_address;
            dbg_cmd_pkg::VID_REG_A:      o_rdata = {8'h00, i_cpu_reg_a};
            dbg_cmd_pkg::VID_REG_X:      o_rdata = {8'h00, i_cpu_reg_x};
            dbg_cmd_pkg::VID_REG_Y:      o_rdata = {8'h00, i_cpu_reg_y};
            dbg_cmd_pkg::VID_REG_S:      o_rdata = {8'h00, i_cpu_reg_s};
            dbg_cmd_pkg::VID_REG_P:      o_rdata = {8'h00, i_cpu_reg_p};
            default:                     o_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/debugger_top.sv */
`timescale 1ns/1ps
`include "dbg_params.svh"
`default_nettype none

module debugger_top (
    input  wire                     i_clk_5mhz,
    input  wire                     i_reset_n,
    input  wire                     i_spi_cs_n,
    input  wire                     i_spi_clk,
    input  wire                     i_spi_copi,
    output wire                     o_spi_cipo,
    input  wire                     i_cpu_rw,
    input  wire dbg_bus_pkg::addr_t i_cpu_address,
    input  wire dbg_bus_pkg::byte_t i_cpu_data,
    output wire dbg_bus_pkg::byte_t o_cpu_data,
    input  wire dbg_bus_pkg::byte_t i_cpu_reg_a,
    input  wire dbg_bus_pkg::byte_t i_cpu_reg_x,
    input  wire dbg_bus_pkg::byte_t i_cpu_reg_y,
    input  wire dbg_bus_pkg::byte_t i_cpu_reg_s,
    input  wire dbg_bus_pkg::byte_t i_cpu_reg_p,
    output wire                     o_cpu_clk_en,
    output wire                     o_cpu_reset_n
);

    wire                          w_rx_dv;
    wire dbg_bus_pkg::byte_t      w_rx_byte;
    wire                          w_tx_dv;
    wire dbg_bus_pkg::byte_t      w_tx_byte;
    wire                          w_active;

    wire                          w_mem_en;
    wire                          w_mem_we;
    wire dbg_bus_pkg::addr_t      w_mem_address;
    wire dbg_bus_pkg::byte_t      w_mem_wdata;
    wire dbg_bus_pkg::byte_t      w_mem_rdata;

    wire                          w_value_en;
    wire                          w_value_we;
    wire dbg_bus_pkg::value_id_t  w_value_id;
    wire dbg_bus_pkg::value_t     w_value_wdata;
    wire dbg_bus_pkg::value_t     w_value_rdata;

    wire                          w_ram_en;
    wire                          w_ram_we;
    wire [`DBG_MEM_ADDR_BITS-1:0] w_ram_index;
    wire dbg_bus_pkg::byte_t      w_ram_wdata;
    wire dbg_bus_pkg::byte_t      w_ram_rdata;

    spi_peripheral u_spi (
        .i_clk_5mhz (i_clk_5mhz),
        .i_reset_n  (i_reset_n),
        .i_spi_cs_n (i_spi_cs_n),
        .i_spi_clk  (i_spi_clk),
        .i_spi_copi (i_spi_copi),
        .o_spi_cipo (o_spi_cipo),
        .i_tx_dv    (w_tx_dv),
        .i_tx_byte  (w_tx_byte),
        .o_rx_dv    (w_rx_dv),
        .o_rx_byte  (w_rx_byte),
        .o_active   (w_active)
    );

    debug_commander u_commander (
        .i_clk_5mhz    (i_clk_5mhz),
        .i_reset_n     (i_reset_n),
        .i_rx_dv       (w_rx_dv),
        .i_rx_byte     (w_rx_byte),
        .i_active      (w_active),
        .o_tx_dv       (w_tx_dv),
        .o_tx_byte     (w_tx_byte),
        .o_mem_en      (w_mem_en),
        .o_mem_we      (w_mem_we),
        .o_mem_address (w_mem_address),
        .o_mem_wdata   (w_mem_wdata),
        .i_mem_rdata   (w_mem_rdata),
        .o_value_en    (w_value_en),
        .o_value_we    (w_value_we),
        .o_value_id    (w_value_id),
        .o_value_wdata (w_value_wdata),
        .i_value_rdata (w_value_rdata)
    );

    debug_values u_values (
        .i_clk_5mhz    (i_clk_5mhz),
        .i_reset_n     (i_reset_n),
        .i_en          (w_value_en),
        .i_we          (w_value_we),
        .i_id          (w_value_id),
        .i_wdata       (w_value_wdata),
        .o_rdata       (w_value_rdata),
        .i_cpu_address (i_cpu_address),
        .i_cpu_reg_a   (i_cpu_reg_a),
        .i_cpu_reg_x   (i_cpu_reg_x),
        .i_cpu_reg_y   (i_cpu_reg_y),
        .i_cpu_reg_s   (i_cpu_reg_s),
        .i_cpu_reg_p   (i_cpu_reg_p),
        .o_cpu_clk_en  (o_cpu_clk_en),
        .o_cpu_reset_n (o_cpu_reset_n)
    );

    mem_arbiter u_arbiter (
        .i_clk_5mhz    (i_clk_5mhz),
        .i_reset_n     (i_reset_n),
        .i_dbg_en      (w_mem_en),
        .i_dbg_we      (w_mem_we),
        .i_dbg_address (w_mem_address),
        .i_dbg_wdata   (w_mem_wdata),
        .o_dbg_rdata   (w_mem_rdata),
        .i_cpu_clk_en  (o_cpu_clk_en),
        .i_cpu_rw      (i_cpu_rw),
        .i_cpu_address (i_cpu_address),
        .i_cpu_data    (i_cpu_data),
        .o_cpu_data    (o_cpu_data),
        .o_ram_en      (w_ram_en),
        .o_ram_we      (w_ram_we),
        .o_ram_index   (w_ram_index),
        .o_ram_wdata   (w_ram_wdata),
        .i_ram_rdata   (w_ram_rdata)
    );

    debug_memory u_memory (
        .i_clk_5mhz (i_clk_5mhz),
        .i_en       (w_ram_en),
        .i_we       (w_ram_we),
        .i_index    (w_ram_index),
        .i_wdata    (w_ram_wdata),
        .o_rdata    (w_ram_rdata)
    );

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps
`include "dbg_params.svh"
`default_nettype none

module mem_arbiter (
    input  wire                          i_clk_5mhz,
    input  wire                          i_reset_n,
    input  wire                          i_dbg_en,
    input  wire                          i_dbg_we,
    input  wire dbg_bus_pkg::addr_t      i_dbg_address,
    input  wire dbg_bus_pkg::byte_t      i_dbg_wdata,
    output dbg_bus_pkg::byte_t           o_dbg_rdata,
    input  wire                          i_cpu_clk_en,
    input  wire                          i_cpu_rw,
    input  wire dbg_bus_pkg::addr_t      i_cpu_address,
    input  wire dbg_bus_pkg::byte_t      i_cpu_data,
    output dbg_bus_pkg::byte_t           o_cpu_data,
    output wire                          o_ram_en,
    output wire                          o_ram_we,
    output wire [`DBG_MEM_ADDR_BITS-1:0] o_ram_index,
    output dbg_bus_pkg::byte_t           o_ram_wdata,
    input  wire dbg_bus_pkg::byte_t      i_ram_rdata
);

    logic               dbg_owner;
    dbg_bus_pkg::byte_t cpu_rdata_q;

    // Processor reads whenever the debugger is idle
    assign o_ram_en    = 1'b1;
    assign o_ram_we    = i_dbg_en ? i_dbg_we : (i_cpu_clk_en & ~i_cpu_rw);
    assign o_ram_index = i_dbg_en ? i_dbg_address[`DBG_MEM_ADDR_BITS-1:0]
                                  : i_cpu_address[`DBG_MEM_ADDR_BITS-1:0];
    assign o_ram_wdata = i_dbg_en ? i_dbg_wdata : i_cpu_data;

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
            dbg_owner <= 1'b0;
        else
            dbg_owner <= i_dbg_en;
    end

    // Processor keeps its last byte while the debugger owns the RAM
    always_ff @(posedge i_clk_5mhz)
    begin
        if (!dbg_owner)
            cpu_rdata_q <= i_ram_rdata;
    end

    assign o_dbg_rdata = dbg_owner ? i_ram_rdata : '0;
    assign o_cpu_data  = dbg_owner ? cpu_rdata_q : i_ram_rdata;

endmodule

`default_nettype wire

/* verilog/spi_peripheral.sv */
`timescale 1ns/1ps
`include "dbg_params.svh"
`default_nettype none

module spi_peripheral (
    input  wire                 i_clk_5mhz,
    input  wire                 i_reset_n,
    input  wire                 i_spi_cs_n,
    input  wire                 i_spi_clk,
    input  wire                 i_spi_copi,
    output wire                 o_spi_cipo,
    input  wire                 i_tx_dv,
    input  wire dbg_bus_pkg::byte_t i_tx_byte,
    output logic                o_rx_dv,
    output dbg_bus_pkg::byte_t  o_rx_byte,
    output wire                 o_active
);

    logic [`DBG_SYNC_STAGES-1:0] cs_sync;
    logic [`DBG_SYNC_STAGES-1:0] sck_sync;
    logic [`DBG_SYNC_STAGES-1:0] copi_sync;
    logic                        sck_prev;
    logic                        sck_rise;
    logic                        sck_fall;
    logic                        copi_bit;
    logic [2:0]                  bit_cnt;
    logic [6:0]                  rx_shift;
    dbg_bus_pkg::byte_t          tx_shift;
    dbg_bus_pkg::byte_t          tx_buf;
    logic                        tx_pending;

    // Pin synchronisers, chip select idles high
    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            cs_sync   <= '1;
            sck_sync  <= '0;
            copi_sync <= '0;
            sck_prev  <= 1'b0;
        end
        else
        begin
            cs_sync   <= {cs_sync[`DBG_SYNC_STAGES-2:0], i_spi_cs_n};
            sck_sync  <= {sck_sync[`DBG_SYNC_STAGES-2:0], i_spi_clk};
            copi_sync <= {copi_sync[`DBG_SYNC_STAGES-2:0], i_spi_copi};
            sck_prev  <= sck_sync[`DBG_SYNC_STAGES-1];
        end
    end

    assign o_active = ~cs_sync[`DBG_SYNC_STAGES-1];
    assign sck_rise = sck_sync[`DBG_SYNC_STAGES-1] & ~sck_prev;
    assign sck_fall = ~sck_sync[`DBG_SYNC_STAGES-1] & sck_prev;
    assign copi_bit = copi_sync[`DBG_SYNC_STAGES-1];

    // Mode 0, MSB first
    assign o_spi_cipo = tx_shift[7];

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            bit_cnt    <= 3'd0;
            rx_shift   <= '0;
            tx_shift   <= '0;
            tx_buf     <= '0;
            tx_pending <= 1'b0;
            o_rx_dv    <= 1'b0;
            o_rx_byte  <= '0;
        end
        else
        begin
            o_rx_dv <= 1'b0;
            if (!o_active)
            begin
                bit_cnt    <= 3'd0;
                tx_shift   <= '0;
                tx_pending <= 1'b0;
            end
            else
            begin
                if (sck_rise)
                begin
                    rx_shift <= {rx_shift[5:0], copi_bit};
                    bit_cnt  <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                    begin
                        o_rx_dv   <= 1'b1;
                        o_rx_byte <= {rx_shift, copi_bit};
                    end
                end
                // Falling edge at a byte boundary starts the next byte
                if (sck_fall)
                begin
                    if (bit_cnt == 3'd0)
                    begin
                        tx_shift   <= tx_pending ? tx_buf : '0;
                        tx_pending <= 1'b0;
                    end
                    else
                    begin
                        tx_shift <= {tx_shift[6:0], 1'b0};
                    end
                end
                if (i_tx_dv)
                begin
                    tx_buf     <= i_tx_byte;
                    tx_pending <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
